// File: i2c_reg_pkg.sv
// I2C register target types
package i2c_reg_pkg;

    // one byte on the bus
    typedef logic [7:0] byte_t;

    // 7-bit target address
    typedef logic [6:0] addr_t;

    // bits per byte minus one
    localparam logic [3:0] BIT_LAST = 4'd7;

    // transfer phases
    typedef enum logic [2:0] {
        ST_IDLE         = 3'd0,
        ST_ADDRESS      = 3'd1,
        ST_ACK          = 3'd2,
        ST_WRITE_SETUP  = 3'd3,
        ST_WRITE_BITS   = 3'd4,
        ST_READ_BITS    = 3'd5,
        ST_READ_RELEASE = 3'd6,
        ST_READ_ACK     = 3'd7
    } target_state_t;

endpackage

// File: i2c_line_filter.sv
// I2C line filter and start/stop detect
`timescale 1ns/1ps

module i2c_line_filter #(
    parameter int FILTER_LEN = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic scl,
    input  logic sda_in,
    output logic scl_level,
    output logic sda_level,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_cond,
    output logic stop_cond
);

    // bit 0 is scl and bit 1 is sda
    logic [1:0] line_pin;
    logic [1:0] line_level;
    logic [1:0] line_last;
    logic [1:0] line_rise;
    logic [1:0] line_fall;

    assign line_pin = {sda_in, scl};

    for (genvar i = 0; i < 2; i++) begin : g_line
        logic [FILTER_LEN-1:0] stages;
        logic                  level_q;
        logic                  last_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                stages  <= '1;
                level_q <= 1'b1;
                last_q  <= 1'b1;
            end else begin
                stages <= {stages[FILTER_LEN-2:0], line_pin[i]};
                // level moves only once every stage agrees
                if (stages == '1) begin
                    level_q <= 1'b1;
                end else if (stages == '0) begin
                    level_q <= 1'b0;
                end
                last_q <= level_q;
            end
        end

        assign line_level[i] = level_q;
        assign line_last[i]  = last_q;
    end

    assign line_rise = line_level & ~line_last;
    assign line_fall = ~line_level & line_last;

    assign scl_level = line_level[0];
    assign sda_level = line_level[1];
    assign scl_rise  = line_rise[0];
    assign scl_fall  = line_fall[0];

    // sda edges while scl is high
    assign start_cond = line_fall[1] & line_level[0];
    assign stop_cond  = line_rise[1] & line_level[0];

endmodule

// File: i2c_bit_counter.sv
// I2C bit counter
`timescale 1ns/1ps

module i2c_bit_counter (
    input  logic clk,
    input  logic rst,
    input  logic cnt_load,
    input  logic cnt_dec,
    output logic cnt_zero
);

    import i2c_reg_pkg::*;

    logic [3:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= 4'd0;
        end else if (cnt_load) begin
            count <= BIT_LAST;
        end else if (cnt_dec && count != 4'd0) begin
            count <= count - 4'd1;
        end
    end

    // current bit is the last of the byte
    assign cnt_zero = (count == 4'd0);

endmodule

// File: i2c_byte_shifter.sv
// I2C byte shifter and data register
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic               clk,
    input  logic               rst,
    input  logic               sda_level,
    input  logic               shift_in,
    input  logic               shift_out,
    input  logic               load_shift,
    input  logic               commit_write,
    input  logic               drive_ack,
    input  logic               release_sda,
    input  logic               data_latch,
    input  i2c_reg_pkg::byte_t data_in,
    output i2c_reg_pkg::byte_t shift_byte,
    output i2c_reg_pkg::byte_t data_out,
    output logic               sda_o,
    output logic               sda_t
);

    import i2c_reg_pkg::*;

    byte_t shift_reg;
    byte_t data_reg;
    logic  sda_drive;

    // msb first and both directions append the sampled line
    always_ff @(posedge clk) begin
        if (load_shift) begin
            shift_reg <= data_reg;
        end else if (shift_in || shift_out) begin
            shift_reg <= {shift_reg[6:0], sda_level};
        end
    end

    // open-drain drive where low pulls sda down
    always_ff @(posedge clk) begin
        if (rst) begin
            sda_drive <= 1'b1;
        end else if (shift_out) begin
            sda_drive <= shift_reg[7];
        end else if (drive_ack) begin
            sda_drive <= 1'b0;
        end else if (release_sda) begin
            sda_drive <= 1'b1;
        end
    end

    // local latch beats a bus write
    always_ff @(posedge clk) begin
        if (rst) begin
            data_reg <= '0;
        end else if (data_latch) begin
            data_reg <= data_in;
        end else if (commit_write) begin
            data_reg <= {shift_reg[6:0], sda_level};
        end
    end

    assign shift_byte = shift_reg;
    assign data_out   = data_reg;
    assign sda_o      = sda_drive;
    assign sda_t      = sda_drive;

endmodule

// File: i2c_target_fsm.sv
// I2C target transfer FSM
`timescale 1ns/1ps

module i2c_target_fsm #(
    parameter i2c_reg_pkg::addr_t DEV_ADDR = 7'h70
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               scl_rise,
    input  logic               scl_fall,
    input  logic               start_cond,
    input  logic               stop_cond,
    input  logic               sda_level,
    input  logic               cnt_zero,
    input  i2c_reg_pkg::byte_t shift_byte,
    output logic               cnt_load,
    output logic               cnt_dec,
    output logic               shift_in,
    output logic               shift_out,
    output logic               load_shift,
    output logic               commit_write,
    output logic               drive_ack,
    output logic               release_sda
);

    import i2c_reg_pkg::*;

    target_state_t state;
    target_state_t state_next;
    logic          mode_read;
    logic          mode_read_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            mode_read <= 1'b0;
        end else begin
            state     <= state_next;
            mode_read <= mode_read_next;
        end
    end

    always_comb begin
        state_next     = state;
        mode_read_next = mode_read;
        cnt_load       = 1'b0;
        cnt_dec        = 1'b0;
        shift_in       = 1'b0;
        shift_out      = 1'b0;
        load_shift     = 1'b0;
        commit_write   = 1'b0;
        drive_ack      = 1'b0;
        release_sda    = 1'b0;

        // start and stop win in any phase
        if (start_cond) begin
            cnt_load    = 1'b1;
            release_sda = 1'b1;
            state_next  = ST_ADDRESS;
        end else if (stop_cond) begin
            release_sda = 1'b1;
            state_next  = ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    state_next = ST_IDLE;
                end
                ST_ADDRESS: begin
                    if (scl_rise) begin
                        if (!cnt_zero) begin
                            shift_in = 1'b1;
                            cnt_dec  = 1'b1;
                        end else begin
                            // eighth bit is r/w and the address sits in the low bits
                            mode_read_next = sda_level;
                            if (shift_byte[6:0] == DEV_ADDR) begin
                                state_next = ST_ACK;
                            end else begin
                                state_next = ST_IDLE;
                            end
                        end
                    end
                end
                ST_ACK: begin
                    if (scl_fall) begin
                        drive_ack = 1'b1;
                        cnt_load  = 1'b1;
                        if (mode_read) begin
                            load_shift = 1'b1;
                            state_next = ST_READ_BITS;
                        end else begin
                            state_next = ST_WRITE_SETUP;
                        end
                    end
                end
                ST_WRITE_SETUP: begin
                    // ack bit done
                    if (scl_fall) begin
                        release_sda = 1'b1;
                        state_next  = ST_WRITE_BITS;
                    end
                end
                ST_WRITE_BITS: begin
                    if (scl_rise) begin
                        shift_in = 1'b1;
                        if (!cnt_zero) begin
                            cnt_dec = 1'b1;
                        end else begin
                            commit_write = 1'b1;
                            state_next   = ST_ACK;
                        end
                    end
                end
                ST_READ_BITS: begin
                    if (scl_fall) begin
                        shift_out = 1'b1;
                        if (!cnt_zero) begin
                            cnt_dec = 1'b1;
                        end else begin
                            state_next = ST_READ_RELEASE;
                        end
                    end
                end
                ST_READ_RELEASE: begin
                    // free the line for the controller ack
                    if (scl_fall) begin
                        release_sda = 1'b1;
                        state_next  = ST_READ_ACK;
                    end
                end
                ST_READ_ACK: begin
                    if (scl_rise) begin
                        if (sda_level) begin
                            state_next = ST_IDLE;
                        end else begin
                            cnt_load   = 1'b1;
                            load_shift = 1'b1;
                            state_next = ST_READ_BITS;
                        end
                    end
                end
                default: begin
                    state_next = ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: i2c_reg_target.sv
// I2C single register target
`timescale 1ns/1ps

module i2c_reg_target #(
    parameter int                 FILTER_LEN = 4,
    parameter i2c_reg_pkg::addr_t DEV_ADDR   = 7'h70
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               scl,
    input  logic               sda_in,
    input  logic               data_latch,
    input  i2c_reg_pkg::byte_t data_in,
    output logic               sda_o,
    output logic               sda_t,
    output i2c_reg_pkg::byte_t data_out
);

    import i2c_reg_pkg::*;

    logic  sda_level;
    logic  scl_rise;
    logic  scl_fall;
    logic  start_cond;
    logic  stop_cond;
    logic  cnt_load;
    logic  cnt_dec;
    logic  cnt_zero;
    logic  shift_in;
    logic  shift_out;
    logic  load_shift;
    logic  commit_write;
    logic  drive_ack;
    logic  release_sda;
    byte_t shift_byte;

    i2c_line_filter #(
        .FILTER_LEN (FILTER_LEN)
    ) i2c_line_filter_inst (
        .clk        (clk),
        .rst        (rst),
        .scl        (scl),
        .sda_in     (sda_in),
        .scl_level  (),
        .sda_level  (sda_level),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_cond (start_cond),
        .stop_cond  (stop_cond)
    );

    i2c_target_fsm #(
        .DEV_ADDR (DEV_ADDR)
    ) i2c_target_fsm_inst (
        .clk          (clk),
        .rst          (rst),
        .scl_rise     (scl_rise),
        .scl_fall     (scl_fall),
        .start_cond   (start_cond),
        .stop_cond    (stop_cond),
        .sda_level    (sda_level),
        .cnt_zero     (cnt_zero),
        .shift_byte   (shift_byte),
        .cnt_load     (cnt_load),
        .cnt_dec      (cnt_dec),
        .shift_in     (shift_in),
        .shift_out    (shift_out),
        .load_shift   (load_shift),
        .commit_write (commit_write),
        .drive_ack    (drive_ack),
        .release_sda  (release_sda)
    );

    i2c_bit_counter i2c_bit_counter_inst (
        .clk      (clk),
        .rst      (rst),
        .cnt_load (cnt_load),
        .cnt_dec  (cnt_dec),
        .cnt_zero (cnt_zero)
    );

    i2c_byte_shifter i2c_byte_shifter_inst (
        .clk          (clk),
        .rst          (rst),
        .sda_level    (sda_level),
        .shift_in     (shift_in),
        .shift_out    (shift_out),
        .load_shift   (load_shift),
        .commit_write (commit_write),
        .drive_ack    (drive_ack),
        .release_sda  (release_sda),
        .data_latch   (data_latch),
        .data_in      (data_in),
        .shift_byte   (shift_byte),
        .data_out     (data_out),
        .sda_o        (sda_o),
        .sda_t        (sda_t)
    );

endmodule

// File: tb_i2c_reg_target.sv
// I2C register target testbench
`timescale 1ns/1ps

module tb_i2c_reg_target;

    import i2c_reg_pkg::*;

    localparam addr_t DEV_ADDR    = 7'h70;
    localparam int    QTR         = 10;
    localparam int    NUM_RANDOM  = 40;
    // up to two bus transactions per test
    localparam int    NUM_TRANS   = 2 * (NUM_RANDOM + 5);
    localparam int    CYCLE_LIMIT = NUM_TRANS * 4 * 9 * 40 + 2000;

    logic  clk = 1'b0;
    logic  rst;
    logic  scl;
    logic  sda_drv;
    logic  data_latch;
    byte_t data_in;
    logic  sda_o;
    logic  sda_t;
    byte_t data_out;
    wire   sda_bus;

    byte_t       model_reg;
    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;

    // only a solid low from the target pulls the line
    assign sda_bus = sda_drv & (sda_o !== 1'b0);

    always #5 clk = ~clk;

    i2c_reg_target #(
        .FILTER_LEN (4),
        .DEV_ADDR   (DEV_ADDR)
    ) i2c_reg_target_inst (
        .clk        (clk),
        .rst        (rst),
        .scl        (scl),
        .sda_in     (sda_bus),
        .data_latch (data_latch),
        .data_in    (data_in),
        .sda_o      (sda_o),
        .sda_t      (sda_t),
        .data_out   (data_out)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_quarter();
        repeat (QTR) @(posedge clk);
    endtask

    // also serves as repeated start when scl is low
    task automatic start_condition();
        sda_drv <= 1'b1;
        wait_quarter();
        scl <= 1'b1;
        wait_quarter();
        sda_drv <= 1'b0;
        wait_quarter();
        scl <= 1'b0;
        wait_quarter();
    endtask

    task automatic stop_condition();
        sda_drv <= 1'b0;
        wait_quarter();
        scl <= 1'b1;
        wait_quarter();
        sda_drv <= 1'b1;
        wait_quarter();
    endtask

    task automatic drive_bit(input logic b);
        sda_drv <= b;
        wait_quarter();
        scl <= 1'b1;
        wait_quarter();
        wait_quarter();
        scl <= 1'b0;
        wait_quarter();
    endtask

    task automatic sample_bit(output logic b);
        sda_drv <= 1'b1;
        wait_quarter();
        scl <= 1'b1;
        wait_quarter();
        // middle of scl high
        @(negedge clk);
        b = sda_bus;
        wait_quarter();
        scl <= 1'b0;
        wait_quarter();
    endtask

    task automatic send_byte(input byte_t value, output logic ack);
        for (int i = 7; i >= 0; i--) begin
            drive_bit(value[i]);
        end
        sample_bit(ack);
    endtask

    task automatic receive_byte(input logic ack, output byte_t value);
        logic b;
        for (int i = 7; i >= 0; i--) begin
            sample_bit(b);
            value[i] = b;
        end
        drive_bit(ack);
    endtask

    task automatic write_register(input byte_t value);
        logic ack;
        start_condition();
        send_byte({DEV_ADDR, 1'b0}, ack);
        check_bit("address ack", ack, 1'b0);
        send_byte(value, ack);
        check_bit("data ack", ack, 1'b0);
        stop_condition();
        model_reg = value;
        @(negedge clk);
        check_byte("data_out after write", data_out, model_reg);
        @(posedge clk);
    endtask

    // every byte but the last is acked by the controller
    task automatic read_register(input int count);
        logic  ack;
        byte_t value;
        start_condition();
        send_byte({DEV_ADDR, 1'b1}, ack);
        check_bit("address ack", ack, 1'b0);
        for (int i = 0; i < count; i++) begin
            receive_byte(i == count - 1, value);
            check_byte("read data", value, model_reg);
        end
        // target lets go of sda after the nack
        @(negedge clk);
        check_bit("sda_t after nack", sda_t, 1'b1);
        @(posedge clk);
        stop_condition();
    endtask

    task automatic probe_wrong_address(input addr_t addr, input logic rw);
        logic ack;
        start_condition();
        send_byte({addr, rw}, ack);
        check_bit("wrong address ack", ack, 1'b1);
        stop_condition();
        @(negedge clk);
        check_byte("data_out after wrong address", data_out, model_reg);
        @(posedge clk);
        read_register(1);
    endtask

    task automatic latch_register(input byte_t value);
        data_in    <= value;
        data_latch <= 1'b1;
        @(posedge clk);
        data_latch <= 1'b0;
        model_reg = value;
        @(negedge clk);
        check_byte("data_out after latch", data_out, model_reg);
        @(posedge clk);
        read_register(1);
    endtask

    // at most 6 bits since the stop adds one more scl rise
    task automatic abort_write(input byte_t partial, input int bits, input byte_t value);
        logic ack;
        start_condition();
        send_byte({DEV_ADDR, 1'b0}, ack);
        check_bit("address ack", ack, 1'b0);
        for (int i = 7; i > 7 - bits; i--) begin
            drive_bit(partial[i]);
        end
        stop_condition();
        @(negedge clk);
        check_byte("data_out after abort", data_out, model_reg);
        @(posedge clk);
        write_register(value);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s ok", test_count, name);
        end else begin
            $display("test %0d %s failed, %0d errors", test_count, name,
                     error_count - errors_before);
        end
    endtask

    task automatic run_test(input int kind, input logic [31:0] r);
        int    errors_before;
        addr_t other;
        errors_before = error_count;
        case (kind)
            0: begin
                write_register(r[7:0]);
                report_test("write", errors_before);
            end
            1: begin
                read_register(1 + r[7:0] % 3);
                report_test("read", errors_before);
            end
            2: begin
                other = r[6:0];
                if (other == DEV_ADDR) begin
                    other = other ^ 7'h01;
                end
                probe_wrong_address(other, r[8]);
                report_test("wrong address", errors_before);
            end
            3: begin
                latch_register(r[7:0]);
                report_test("local latch", errors_before);
            end
            default: begin
                abort_write(r[7:0], 1 + r[15:8] % 6, r[23:16]);
                report_test("aborted write", errors_before);
            end
        endcase
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          errors_before;
        rst        = 1'b1;
        scl        = 1'b1;
        sda_drv    = 1'b1;
        data_latch = 1'b0;
        data_in    = '0;
        model_reg  = '0;
        rng_state  = 32'd77;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        errors_before = error_count;
        check_byte("data_out", data_out, 8'h00);
        check_bit("sda_t", sda_t, 1'b1);
        report_test("reset", errors_before);
        @(posedge clk);

        // each kind once, then a random mix
        for (int k = 0; k < 5; k++) begin
            next_random(r2);
            run_test(k, r2);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            next_random(r);
            next_random(r2);
            run_test(r % 5, r2);
        end

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: i2c_reg_target.f
i2c_reg_pkg.sv
i2c_line_filter.sv
i2c_bit_counter.sv
i2c_byte_shifter.sv
i2c_target_fsm.sv
i2c_reg_target.sv
tb_i2c_reg_target.sv
